// ==== flist.f ====
rtl/synth_pkg.sv
rtl/timing_gen.sv
rtl/slot_ram.sv
rtl/synth_clk_gen.sv
rtl/env_engine.sv
rtl/frame_mixer.sv
rtl/synth_timing_top.sv
test/synth_timing_props.sv
test/synth_timing_tb.sv

// ==== test/synth_timing_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module synth_timing_tb;

    logic                               AUDIO_CLK;
    logic                               reset_reg_N;
    logic                               trig;
    logic                               cfg_we;
    logic [synth_pkg::SLOT_WIDTH-1:0]   cfg_slot;
    synth_pkg::env_rate_t               cfg_rate;
    logic                               sCLK_XVXOSC;
    logic                               level_valid;
    logic [synth_pkg::SLOT_WIDTH-1:0]   level_slot;
    synth_pkg::env_level_t              level;
    logic [synth_pkg::SUM_WIDTH-1:0]    frame_sum;
    logic                               frame_done;

    synth_pkg::env_level_t  model_level [synth_pkg::NUM_SLOTS];
    synth_pkg::env_rate_t   model_rate  [synth_pkg::NUM_SLOTS];
    logic [15:0]            lfsr_state;
    int                     test_errors;
    int                     total_errors;
    int                     tests_failed;
    int                     prop_errors;
    logic [15:0]            rnd;

    synth_timing_top UUT (
        .AUDIO_CLK   (AUDIO_CLK),
        .reset_reg_N (reset_reg_N),
        .trig        (trig),
        .cfg_we      (cfg_we),
        .cfg_slot    (cfg_slot),
        .cfg_rate    (cfg_rate),
        .sCLK_XVXOSC (sCLK_XVXOSC),
        .level_valid (level_valid),
        .level_slot  (level_slot),
        .level       (level),
        .frame_sum   (frame_sum),
        .frame_done  (frame_done)
    );

    initial begin
        AUDIO_CLK = 1'b0;
        forever #2 AUDIO_CLK = ~AUDIO_CLK;          // 4 ns period
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;             // galois taps 16,14,13,11
        end
        return s >> 1;
    endfunction

    task automatic rand_bits(input int n, output logic [15:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[14:0], lfsr_state[0]};       // one step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic synth_pkg::env_level_t sat_add(input synth_pkg::env_level_t lvl,
                                                      input synth_pkg::env_rate_t rate);
        logic [16:0] s;
        s = {1'b0, lvl} + {9'd0, rate};
        if (s[16]) begin
            return synth_pkg::LEVEL_MAX;
        end
        return s[15:0];
    endfunction

    task automatic tick();
        @(posedge AUDIO_CLK);
        #1;                                         // drive and sample past the edge
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end
        else begin
            $display("%s: %0d errors", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic write_rate(input logic [5:0] slot, input synth_pkg::env_rate_t rate);
        cfg_we   = 1'b1;
        cfg_slot = slot;
        cfg_rate = rate;
        tick();
        cfg_we = 1'b0;
        model_rate[slot]  = rate;
        model_level[slot] = '0;                     // host write clears the level
    endtask

    //////////////////////////////////////////////////
    // one frame, checked slot by slot
    //////////////////////////////////////////////////

    task automatic run_frame(input bit mid_trig);
        int          seen;
        int          idle;
        int          osc_rises;
        logic        osc_prev;
        logic [5:0]  slot;
        logic [31:0] exp_sum;
        seen      = 0;
        idle      = 0;
        osc_rises = 0;
        osc_prev  = sCLK_XVXOSC;
        exp_sum   = 0;
        trig      = 1'b1;
        while (seen < synth_pkg::NUM_SLOTS) begin
            tick();
            trig = mid_trig && (seen >= 20) && (seen < 24);  // edge while busy
            idle++;
            if (idle > 64) begin
                abort_run("level_valid stopped arriving");
            end
            if (sCLK_XVXOSC && !osc_prev) begin
                osc_rises++;
            end
            osc_prev = sCLK_XVXOSC;
            assert (!frame_done) else begin
                $display("frame_done arrived before slot 0 at %0t", $time);
                test_errors++;
            end
            if (level_valid) begin
                // trigger edge 2, run 1, first slot clock rise 9, update 3
                check_value("level_valid spacing", idle, (seen == 0) ? 15 : 16);
                slot = 6'(seen + 1);                // 1..63 then 0
                model_level[slot] = sat_add(model_level[slot], model_rate[slot]);
                check_value("level_slot", level_slot, slot);
                check_value("level", level, model_level[slot]);
                exp_sum += model_level[slot];
                seen++;
                idle = 0;
            end
        end
        check_value("sCLK_XVXOSC rises", osc_rises, 32);  // half the slot count
        idle = 0;
        do begin
            tick();
            idle++;
            if (idle > 8) begin
                abort_run("frame_done did not follow slot 0");
            end
        end while (!frame_done);
        check_value("frame_done latency", idle, 1);
        check_value("frame_sum", frame_sum, exp_sum);
        for (int i = 0; i < 24; i++) begin          // no extra frame or updates
            tick();
            assert (!level_valid && !frame_done) else begin
                $display("unexpected level_valid or frame_done after the frame at %0t", $time);
                test_errors++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////

    initial begin
        reset_reg_N  = 1'b0;
        trig         = 1'b0;
        cfg_we       = 1'b0;
        cfg_slot     = '0;
        cfg_rate     = '0;
        lfsr_state   = 16'd13;
        test_errors  = 0;
        total_errors = 0;
        tests_failed = 0;
        prop_errors  = 0;
        repeat (16) tick();
        reset_reg_N = 1'b1;

        for (int i = 0; i < 200; i++) begin
            tick();
            check_value("level_valid", level_valid, 0);
            check_value("frame_done", frame_done, 0);
            check_value("sCLK_XVXOSC", sCLK_XVXOSC, 0);
        end
        finish_test("test 1 idle after reset");

        for (int s = 0; s < synth_pkg::NUM_SLOTS; s++) begin
            rand_bits(8, rnd);
            write_rate(6'(s), rnd[7:0]);
        end
        run_frame(1'b0);
        finish_test("test 2 first frame");

        write_rate(6'd0, 8'hFF);                    // these reach full scale
        write_rate(6'd3, 8'hFF);
        write_rate(6'd30, 8'hFF);
        for (int f = 0; f < 260; f++) begin
            run_frame(1'b0);
        end
        finish_test("test 3 saturation");

        for (int f = 0; f < 4; f++) begin
            run_frame(1'b0);
        end
        finish_test("test 4 frame sums");

        run_frame(1'b1);
        finish_test("test 5 trigger during frame");

        for (int i = 0; i < 4; i++) begin
            rand_bits(14, rnd);
            write_rate(rnd[13:8], rnd[7:0]);
        end
        run_frame(1'b0);
        finish_test("test 6 rewrite between frames");

        prop_errors = UUT.clk_gen_inst.clk_gen_props.fail_count;
        $display("tests run 6, tests failed %0d, checks failed %0d, assertions failed %0d",
                 tests_failed, total_errors, prop_errors);
        if (total_errors == 0 && prop_errors == 0) begin
            $display("TEST PASS");
        end
        else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/synth_timing_props.sv ====
`timescale 1ns/10ps
`default_nettype none

module synth_timing_props (
    input  logic                                AUDIO_CLK,
    input  logic                                reset_reg_N,
    input  logic                                trig_rising,
    input  logic                                run,
    input  logic                                sCLK_XVXOSC,
    input  logic                                sCLK_XVXENVS,
    input  logic [synth_pkg::SLOT_WIDTH-1:0]    xxxx,
    input  logic                                xxxx_zero
);

    int fail_count = 0;     // failed assertion count

    //////////////////////////////////////////////////
    // run control and divided clocks
    //////////////////////////////////////////////////

    clocks_idle: assert property (@(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        !run |-> (!sCLK_XVXOSC && !sCLK_XVXENVS))
        else begin
            $error("slot clocks running while run is low");
            fail_count++;
        end

    run_from_trig: assert property (@(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        $rose(run) |-> $past(trig_rising))
        else begin
            $error("run rose without a trigger edge");
            fail_count++;
        end

    run_stops: assert property (@(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        $rose(xxxx_zero) |-> ##[1:3] !run)
        else begin
            $error("run still high 3 cycles after the slot index wrapped");
            fail_count++;
        end

    index_held: assert property (@(posedge AUDIO_CLK) disable iff (!reset_reg_N)
        !run |-> $stable(xxxx))
        else begin
            $error("slot index moved while idle");
            fail_count++;
        end

endmodule

bind synth_clk_gen synth_timing_props clk_gen_props (
    .AUDIO_CLK    (AUDIO_CLK),
    .reset_reg_N  (reset_reg_N),
    .trig_rising  (trig_rising),
    .run          (run),
    .sCLK_XVXOSC  (sCLK_XVXOSC),
    .sCLK_XVXENVS (sCLK_XVXENVS),
    .xxxx         (xxxx),
    .xxxx_zero    (xxxx_zero)
);

`default_nettype wire

// ==== rtl/synth_timing_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module synth_timing_top (
    input  logic                                AUDIO_CLK,
    input  logic                                reset_reg_N,
    input  logic                                trig,
    input  logic                                cfg_we,
    input  logic [synth_pkg::SLOT_WIDTH-1:0]    cfg_slot,
    input  synth_pkg::env_rate_t                cfg_rate,
    output logic                                sCLK_XVXOSC,    // to the oscillators
    output logic                                level_valid,
    output logic [synth_pkg::SLOT_WIDTH-1:0]    level_slot,
    output synth_pkg::env_level_t               level,
    output logic [synth_pkg::SUM_WIDTH-1:0]     frame_sum,
    output logic                                frame_done
);

    logic                               sCLK_XVXENVS;
    logic [synth_pkg::SLOT_WIDTH-1:0]   xxxx;

    //////////////////////////////////////////////////
    // clocks, slot engine, frame sum
    //////////////////////////////////////////////////

    synth_clk_gen clk_gen_inst (
        .reset_reg_N  (reset_reg_N),
        .AUDIO_CLK    (AUDIO_CLK),
        .trig         (trig),
        .sCLK_XVXOSC  (sCLK_XVXOSC),
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .xxxx         (xxxx),
        .xxxx_zero    ()                // used inside for run control
    );

    env_engine env_engine_inst (
        .AUDIO_CLK    (AUDIO_CLK),
        .reset_reg_N  (reset_reg_N),
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .xxxx         (xxxx),
        .cfg_we       (cfg_we),
        .cfg_slot     (cfg_slot),
        .cfg_rate     (cfg_rate),
        .level_valid  (level_valid),
        .level_slot   (level_slot),
        .level        (level)
    );

    frame_mixer frame_mixer_inst (
        .AUDIO_CLK    (AUDIO_CLK),
        .reset_reg_N  (reset_reg_N),
        .level_valid  (level_valid),
        .level_slot   (level_slot),
        .level        (level),
        .frame_sum    (frame_sum),
        .frame_done   (frame_done)
    );

endmodule

`default_nettype wire

// ==== rtl/frame_mixer.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_mixer (
    input  logic                                AUDIO_CLK,
    input  logic                                reset_reg_N,
    input  logic                                level_valid,
    input  logic [synth_pkg::SLOT_WIDTH-1:0]    level_slot,
    input  synth_pkg::env_level_t               level,
    output logic [synth_pkg::SUM_WIDTH-1:0]     frame_sum,
    output logic                                frame_done
);

    logic [synth_pkg::SUM_WIDTH-1:0] acc;
    logic [synth_pkg::SUM_WIDTH-1:0] level_ext;
    logic                            last_slot;

    assign level_ext = {{(synth_pkg::SUM_WIDTH - $bits(synth_pkg::env_level_t)){1'b0}}, level};
    assign last_slot = (level_slot == '0);     // slot 0 closes the frame

    //////////////////////////////////////////////////
    // per-frame accumulation
    //////////////////////////////////////////////////

    always_ff @(posedge AUDIO_CLK or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            acc        <= '0;
            frame_sum  <= '0;
            frame_done <= 1'b0;
        end
        else begin
            frame_done <= 1'b0;
            if (level_valid) begin
                if (last_slot) begin
                    frame_sum  <= acc + level_ext;  // held until next frame
                    frame_done <= 1'b1;
                    acc        <= '0;
                end
                else begin
                    acc <= acc + level_ext;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/env_engine.sv ====
`timescale 1ns/10ps
`default_nettype none

module env_engine (
    input  logic                                AUDIO_CLK,
    input  logic                                reset_reg_N,
    input  logic                                sCLK_XVXENVS,
    input  logic [synth_pkg::SLOT_WIDTH-1:0]    xxxx,
    input  logic                                cfg_we,     // host strobe
    input  logic [synth_pkg::SLOT_WIDTH-1:0]    cfg_slot,
    input  synth_pkg::env_rate_t                cfg_rate,
    output logic                                level_valid,
    output logic [synth_pkg::SLOT_WIDTH-1:0]    level_slot,
    output synth_pkg::env_level_t               level
);

    logic                               sclk_d;
    logic                               slot_stb;
    logic                               rd_valid;
    logic [synth_pkg::SLOT_WIDTH-1:0]   rd_slot;
    synth_pkg::env_level_t              lvl_rdata;
    synth_pkg::env_rate_t               rate_rdata;
    logic [$bits(synth_pkg::env_level_t):0] lvl_sum;
    synth_pkg::env_level_t              new_level;
    logic                               lvl_we;
    logic [synth_pkg::SLOT_WIDTH-1:0]   lvl_waddr;
    synth_pkg::env_level_t              lvl_wdata;

    //////////////////////////////////////////////////
    // slot clock rise to local strobe, then pipeline
    //////////////////////////////////////////////////

    always_ff @(posedge AUDIO_CLK or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            sclk_d      <= 1'b0;
            slot_stb    <= 1'b0;
            rd_valid    <= 1'b0;
            level_valid <= 1'b0;
        end
        else begin
            sclk_d      <= sCLK_XVXENVS;
            slot_stb    <= sCLK_XVXENVS && !sclk_d;  // stage 1 rise seen
            rd_valid    <= slot_stb;                 // stage 2 read issued
            level_valid <= rd_valid;                 // stage 3 write back
        end
    end

    always_ff @(posedge AUDIO_CLK) begin
        rd_slot <= xxxx;
        if (rd_valid) begin
            level_slot <= rd_slot;
            level      <= new_level;
        end
    end

    // level plus rate, clipped at full scale
    always_comb begin
        lvl_sum = {1'b0, lvl_rdata}
                + {{($bits(synth_pkg::env_level_t) - $bits(synth_pkg::env_rate_t) + 1){1'b0}},
                   rate_rdata};
        if (lvl_sum[$bits(synth_pkg::env_level_t)]) begin
            new_level = synth_pkg::LEVEL_MAX;
        end
        else begin
            new_level = lvl_sum[$bits(synth_pkg::env_level_t)-1:0];
        end
    end

    // host rate write also zeroes that slot's level
    assign lvl_we    = rd_valid || cfg_we;
    assign lvl_waddr = cfg_we ? cfg_slot : rd_slot;
    assign lvl_wdata = cfg_we ? '0 : new_level;

    //////////////////////////////////////////////////
    // slot memories
    //////////////////////////////////////////////////

    slot_ram #(.T(synth_pkg::env_level_t)) level_ram (
        .AUDIO_CLK (AUDIO_CLK),
        .we        (lvl_we),
        .waddr     (lvl_waddr),
        .wdata     (lvl_wdata),
        .raddr     (xxxx),
        .rdata     (lvl_rdata)
    );

    slot_ram #(.T(synth_pkg::env_rate_t)) rate_ram (
        .AUDIO_CLK (AUDIO_CLK),
        .we        (cfg_we),        // host only
        .waddr     (cfg_slot),
        .wdata     (cfg_rate),
        .raddr     (xxxx),
        .rdata     (rate_rdata)
    );

endmodule

`default_nettype wire

// ==== rtl/synth_clk_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module synth_clk_gen (
    input  logic                                reset_reg_N,
    input  logic                                AUDIO_CLK,  // ~90.4 MHz
    input  logic                                trig,
    output logic                                sCLK_XVXOSC,
    output logic                                sCLK_XVXENVS,
    output logic [synth_pkg::SLOT_WIDTH-1:0]    xxxx,       // slot index
    output logic                                xxxx_zero
);

    logic [synth_pkg::XVXOSC_WIDTH:0]   sclk_xvxosc_div;
    logic [synth_pkg::XVXENVS_WIDTH:0]  sclk_xvxenvs_div;
    logic                               trig_sync;
    logic                               trig_dly;
    logic                               trig_rising;
    logic                               run;
    logic [1:0]                         xxxx_zero_dly;
    logic                               zero_rise;

    //////////////////////////////////////////////////
    // trigger edge and wrap delay
    //////////////////////////////////////////////////

    always_ff @(posedge AUDIO_CLK or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            trig_sync     <= 1'b0;
            trig_dly      <= 1'b0;
            trig_rising   <= 1'b0;
            xxxx_zero_dly <= 2'b00;
        end
        else begin
            trig_sync     <= trig;                   // trigger input stage
            trig_dly      <= trig_sync;
            trig_rising   <= trig_sync && !trig_dly;
            xxxx_zero_dly <= {xxxx_zero_dly[0], xxxx_zero};  // slot clock domain in
        end
    end

    // wrap flag stays high between frames, so only its rise stops the run
    assign zero_rise = xxxx_zero_dly[0] && !xxxx_zero_dly[1];

    always_ff @(posedge AUDIO_CLK or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            run <= 1'b0;
        end
        else if (zero_rise) begin
            run <= 1'b0;                    // frame complete
        end
        else if (trig_rising && !run) begin
            run <= 1'b1;                    // new frame only while idle
        end
    end

    //////////////////////////////////////////////////
    // divided slot clocks, held in reset while idle
    //////////////////////////////////////////////////

    always_ff @(posedge AUDIO_CLK or negedge run) begin
        if (!run) begin
            sclk_xvxosc_div  <= '0;
            sclk_xvxenvs_div <= '0;
            sCLK_XVXOSC      <= 1'b0;
            sCLK_XVXENVS     <= 1'b0;
        end
        else begin
            if (sclk_xvxosc_div >= (synth_pkg::XVXOSC_WIDTH + 1)'(synth_pkg::XVOSC_DIV)) begin
                sclk_xvxosc_div <= {{synth_pkg::XVXOSC_WIDTH{1'b0}}, 1'b1};
                sCLK_XVXOSC     <= ~sCLK_XVXOSC;
            end
            else begin
                sclk_xvxosc_div <= sclk_xvxosc_div + 1'b1;
            end
            if (sclk_xvxenvs_div >=
                    (synth_pkg::XVXENVS_WIDTH + 1)'(synth_pkg::XVXENVS_DIV)) begin
                sclk_xvxenvs_div <= {{synth_pkg::XVXENVS_WIDTH{1'b0}}, 1'b1};
                sCLK_XVXENVS     <= ~sCLK_XVXENVS;
            end
            else begin
                sclk_xvxenvs_div <= sclk_xvxenvs_div + 1'b1;
            end
        end
    end

    timing_gen timing_gen_inst (
        .reset_reg_N  (reset_reg_N),
        .sCLK_XVXENVS (sCLK_XVXENVS),
        .xxxx         (xxxx),
        .xxxx_zero    (xxxx_zero)
    );

endmodule

`default_nettype wire

// ==== rtl/slot_ram.sv ====
`timescale 1ns/10ps
`default_nettype none

module slot_ram #(
    parameter type T = synth_pkg::env_rate_t
) (
    input  logic                                AUDIO_CLK,
    input  logic                                we,
    input  logic [synth_pkg::SLOT_WIDTH-1:0]    waddr,
    input  T                                    wdata,
    input  logic [synth_pkg::SLOT_WIDTH-1:0]    raddr,
    output T                                    rdata
);

    //////////////////////////////////////////////////
    // one entry per voice/envelope slot
    //////////////////////////////////////////////////

    T mem [synth_pkg::NUM_SLOTS];

    always_ff @(posedge AUDIO_CLK) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // registered read, old data on a same-address write
    always_ff @(posedge AUDIO_CLK) begin
        rdata <= mem[raddr];
    end

endmodule

`default_nettype wire

// ==== rtl/timing_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module timing_gen (
    input  logic                                reset_reg_N,
    input  logic                                sCLK_XVXENVS,   // slot clock
    output logic [synth_pkg::SLOT_WIDTH-1:0]    xxxx,
    output logic                                xxxx_zero
);

    // one extra bit catches the wrap
    logic [synth_pkg::SLOT_WIDTH:0] xxxx_inc;

    assign xxxx_inc = {1'b0, xxxx} + {{synth_pkg::SLOT_WIDTH{1'b0}}, 1'b1};

    //////////////////////////////////////////////////
    // slot index, steps once per slot clock rise
    //////////////////////////////////////////////////

    // the index rolls 1..63 then 0, so slot 0 is the
    // last update of every frame

    always_ff @(posedge sCLK_XVXENVS or negedge reset_reg_N) begin
        if (!reset_reg_N) begin
            xxxx      <= '0;
            xxxx_zero <= 1'b0;
        end
        else begin
            xxxx      <= xxxx_inc[synth_pkg::SLOT_WIDTH-1:0];
            xxxx_zero <= xxxx_inc[synth_pkg::SLOT_WIDTH];  // high on the wrap edge only
        end
    end

    // xxxx_zero keeps its value once the slot clock stops,
    // which leaves it high between frames

endmodule

`default_nettype wire

// ==== rtl/synth_pkg.sv ====
`default_nettype none

package synth_pkg;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    // ceiling of log2, used for counter widths
    function automatic int clogb2(input int value);
        int v;
        int w;
        v = value - 1;
        w = 0;
        while (v > 0) begin
            w = w + 1;
            v = v >> 1;
        end
        return w;
    endfunction

    //////////////////////////////////////////////////
    // voice / envelope geometry
    //////////////////////////////////////////////////

    localparam int VOICES     = 8;
    localparam int V_OSC      = 4;              // oscs per voice
    localparam int V_ENVS     = 2 * V_OSC;      // envelopes per voice
    localparam int V_WIDTH    = 3;
    localparam int E_WIDTH    = 3;
    localparam int SLOT_WIDTH = V_WIDTH + E_WIDTH;  // width of xxxx
    localparam int NUM_SLOTS  = VOICES * V_ENVS;    // slots per frame

    //////////////////////////////////////////////////
    // clock plan
    //////////////////////////////////////////////////

    localparam int AUDIO_CLK_RATE = 90416666;   // ~90.4 MHz
    localparam int AUDIO_REF_CLK  = 16934400;
    localparam int OVERSAMPLING   = 384;
    localparam int SAMPLE_RATE    = AUDIO_REF_CLK / OVERSAMPLING;  // 44.1 kHz

    // divider terminal counts, 16 and 8 for this clock plan
    localparam int XVOSC_DIV   = AUDIO_CLK_RATE / ((SAMPLE_RATE * VOICES * V_OSC * 4) - 1);
    localparam int XVXENVS_DIV = AUDIO_CLK_RATE / ((SAMPLE_RATE * VOICES * V_ENVS * 4) - 1);

    localparam int XVXOSC_WIDTH  = clogb2(XVOSC_DIV);
    localparam int XVXENVS_WIDTH = clogb2(XVXENVS_DIV);

    //////////////////////////////////////////////////
    // envelope payloads
    //////////////////////////////////////////////////

    typedef logic [15:0] env_level_t;   // unsigned level
    typedef logic [7:0]  env_rate_t;    // increment per frame

    localparam env_level_t LEVEL_MAX = '1;  // saturation point

    // 64 full-scale levels fit without overflow
    localparam int SUM_WIDTH = $bits(env_level_t) + SLOT_WIDTH;

endpackage

`default_nettype wire
